/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_core
RTL_TOP   ?= ooo_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 1000
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) 2>&1 | tee $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/alu_station.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_station import ooo_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dispatch,
    input  issue_t issue,
    input  cdb_t   alu_cdb_in,
    input  cdb_t   mul_cdb,
    output logic   busy,
    output cdb_t   alu_cdb
);

    issue_t          ent;
    logic            fire;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;

    assign a    = ent.src[0].value;
    assign b    = ent.src[1].value;
    assign fire = busy && ent.src[0].ready && ent.src[1].ready;

    always_comb begin
        case (ent.op)
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            alu_cdb.valid <= 1'b0;
        end else begin
            alu_cdb.valid <= 1'b0;
            if (dispatch) begin
                busy <= 1'b1;
                ent  <= issue;
            end else if (fire) begin
                busy    <= 1'b0;  // frees with the broadcast
                alu_cdb <= '{valid: 1'b1, tag: ent.dest, value: result};
            end else if (busy) begin
                ent.src[0] <= snoop_operand(ent.src[0], alu_cdb_in, mul_cdb);
                ent.src[1] <= snoop_operand(ent.src[1], alu_cdb_in, mul_cdb);
            end
        end
    end

endmodule

`default_nettype wire

/* design/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile import ooo_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  commit_t              commit,
    input  areg_t [1:0]          rs_addr,
    output logic [1:0][xlen-1:0] rdata
);

    logic [xlen-1:0] regs [num_arch_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin  // x0 stays zero
            regs[commit.rd] <= commit.value;
        end
    end

    always_comb begin
        rdata[0] = regs[rs_addr[0]];
        rdata[1] = regs[rs_addr[1]];
    end

endmodule

`default_nettype wire

/* design/dispatch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_control import ooo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  logic [31:0]           inst,
    input  logic                  rob_full,
    input  tag_t                  rob_tail,
    input  operand_t [1:0]        rob_ready_val,
    input  logic [1:0][xlen-1:0]  rf_rdata,
    input  logic                  alu_busy,
    input  logic                  mul_busy,
    input  cdb_t                  alu_cdb,
    input  cdb_t                  mul_cdb,
    input  commit_t               commit,
    input  tag_t                  commit_tag,
    output logic                  stall,
    output logic                  alloc,
    output areg_t                 alloc_rd,
    output areg_t [1:0]           rs_addr,
    output tag_t [1:0]            lookup_tag,
    output issue_t                issue,
    output logic                  alu_dispatch,
    output logic                  mul_dispatch
);

    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm;
    op_e             dec_op;
    logic            supported;
    operand_t [1:0]  src;

    logic [num_arch_regs-1:0] rat_valid;          // set = renamed to rat_tag
    tag_t                     rat_tag [num_arch_regs];

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign imm      = {{20{inst[31]}}, inst[31:20]};
    assign alloc_rd = inst[11:7];

    always_comb begin
        dec_op    = op_add;
        supported = 1'b0;
        if (opcode == opc_op) begin
            supported = 1'b1;
            case ({funct7, funct3})
                {7'h00, 3'b000}:      dec_op = op_add;
                {funct7_alt, 3'b000}: dec_op = op_sub;
                {7'h00, 3'b111}:      dec_op = op_and;
                {7'h00, 3'b110}:      dec_op = op_or;
                {7'h00, 3'b100}:      dec_op = op_xor;
                {7'h00, 3'b010}:      dec_op = op_slt;
                {funct7_mul, 3'b000}: dec_op = op_mul;
                default:              supported = 1'b0;
            endcase
        end else if (opcode == opc_op_imm && funct3 == 3'b000) begin
            supported = 1'b1;  // addi
        end
    end

    // unsupported words fall through without stalling
    assign stall = inst_valid && supported &&
                   (rob_full || (dec_op == op_mul ? mul_busy : alu_busy));
    assign alloc        = inst_valid && supported && !stall;
    assign alu_dispatch = alloc && dec_op != op_mul;
    assign mul_dispatch = alloc && dec_op == op_mul;

    always_comb begin
        rs_addr[0]    = inst[19:15];
        rs_addr[1]    = inst[24:20];
        lookup_tag[0] = rat_tag[inst[19:15]];
        lookup_tag[1] = rat_tag[inst[24:20]];
    end

    // operands come from the regfile, a finished rob entry or a broadcast this edge
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src[i].tag = lookup_tag[i];
            if (!rat_valid[rs_addr[i]]) begin
                src[i].ready = 1'b1;
                src[i].value = rf_rdata[i];
            end else begin
                src[i].ready = rob_ready_val[i].ready;
                src[i].value = rob_ready_val[i].value;
                src[i]       = snoop_operand(src[i], alu_cdb, mul_cdb);
            end
        end
        if (opcode == opc_op_imm) begin
            src[1] = '{ready: 1'b1, tag: '0, value: imm};
        end
    end

    assign issue = '{op: dec_op, dest: rob_tail, src: src};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rat_valid <= '0;
        end else begin
            if (commit.valid && rat_valid[commit.rd] && rat_tag[commit.rd] == commit_tag) begin
                rat_valid[commit.rd] <= 1'b0;
            end
            // a new writer wins over a retiring one
            if (alloc && alloc_rd != '0) begin
                rat_valid[alloc_rd] <= 1'b1;
                rat_tag[alloc_rd]   <= rob_tail;
            end
        end
    end

endmodule

`default_nettype wire

/* design/mul_station.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_station import ooo_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   dispatch,
    input  issue_t issue,
    input  cdb_t   alu_cdb,
    input  cdb_t   mul_cdb_in,
    output logic   busy,
    output cdb_t   mul_cdb
);

    issue_t          ent;
    logic            running;
    logic            start;
    mstep_t          step;
    logic [xlen-1:0] acc;
    logic [xlen-1:0] mcand;
    logic [xlen-1:0] mplier;
    logic [xlen-1:0] cur_acc;
    logic [xlen-1:0] cur_mcand;
    logic [xlen-1:0] cur_mplier;
    logic [xlen-1:0] next_acc;

    assign start = busy && !running && ent.src[0].ready && ent.src[1].ready;

    // first step runs straight off the entry operands
    always_comb begin
        if (running) begin
            cur_acc    = acc;
            cur_mcand  = mcand;
            cur_mplier = mplier;
        end else begin
            cur_acc    = '0;
            cur_mcand  = ent.src[0].value;
            cur_mplier = ent.src[1].value;
        end
        next_acc = cur_acc + cur_mcand * {{(xlen-mul_bits){1'b0}}, cur_mplier[mul_bits-1:0]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            running       <= 1'b0;
            step          <= '0;
            mul_cdb.valid <= 1'b0;
        end else begin
            mul_cdb.valid <= 1'b0;
            if (dispatch) begin
                busy <= 1'b1;
                ent  <= issue;
            end else if (start || running) begin
                acc    <= next_acc;
                mcand  <= cur_mcand << mul_bits;
                mplier <= cur_mplier >> mul_bits;
                if (start) begin
                    running <= 1'b1;
                    step    <= mstep_t'(1);
                end else if (step == mstep_t'(mul_steps - 1)) begin
                    running <= 1'b0;
                    busy    <= 1'b0;
                    mul_cdb <= '{valid: 1'b1, tag: ent.dest, value: next_acc};  // low word only
                end else begin
                    step <= step + 1'b1;
                end
            end else if (busy) begin
                ent.src[0] <= snoop_operand(ent.src[0], alu_cdb, mul_cdb_in);
                ent.src[1] <= snoop_operand(ent.src[1], alu_cdb, mul_cdb_in);
            end
        end
    end

endmodule

`default_nettype wire

/* design/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        stall,
    output commit_t     commit
);

    logic                 alloc;
    logic                 rob_full;
    logic                 alu_dispatch;
    logic                 mul_dispatch;
    logic                 alu_busy;
    logic                 mul_busy;
    areg_t                alloc_rd;
    areg_t [1:0]          rs_addr;
    tag_t                 rob_tail;
    tag_t                 commit_tag;
    tag_t [1:0]           lookup_tag;
    operand_t [1:0]       lookup;
    logic [1:0][xlen-1:0] rf_rdata;
    issue_t               issue;
    cdb_t                 alu_cdb;
    cdb_t                 mul_cdb;

    dispatch_control u_dispatch_control (
        .clk, .rst_n, .inst_valid, .inst,
        .rob_full, .rob_tail,
        .rob_ready_val (lookup),
        .rf_rdata, .alu_busy, .mul_busy,
        .alu_cdb, .mul_cdb, .commit, .commit_tag,
        .stall, .alloc, .alloc_rd, .rs_addr, .lookup_tag,
        .issue, .alu_dispatch, .mul_dispatch
    );

    reorder_buffer u_reorder_buffer (
        .clk, .rst_n, .alloc, .alloc_rd, .lookup_tag,
        .alu_cdb, .mul_cdb,
        .rob_full, .rob_tail, .lookup, .commit, .commit_tag
    );

    arch_regfile u_arch_regfile (
        .clk, .rst_n, .commit, .rs_addr,
        .rdata (rf_rdata)
    );

    alu_station u_alu_station (
        .clk, .rst_n,
        .dispatch   (alu_dispatch),
        .issue,
        .alu_cdb_in (alu_cdb),
        .mul_cdb,
        .busy       (alu_busy),
        .alu_cdb
    );

    mul_station u_mul_station (
        .clk, .rst_n,
        .dispatch   (mul_dispatch),
        .issue,
        .alu_cdb,
        .mul_cdb_in (mul_cdb),
        .busy       (mul_busy),
        .mul_cdb
    );

endmodule

`default_nettype wire

/* design/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int xlen          = 32;
    localparam int num_arch_regs = 32;
    localparam int rob_depth     = 8;
    localparam int mul_steps     = 4;
    localparam int mul_bits      = xlen / mul_steps;  // multiplier bits per step

    // rv32 major opcodes and funct7 markers
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] funct7_mul = 7'b0000001;
    localparam logic [6:0] funct7_alt = 7'b0100000;

    typedef logic [$clog2(num_arch_regs)-1:0] areg_t;
    typedef logic [$clog2(rob_depth)-1:0]     tag_t;      // rob index
    typedef logic [$clog2(rob_depth):0]       rob_cnt_t;
    typedef logic [$clog2(mul_steps)-1:0]     mstep_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_mul
    } op_e;

    typedef struct packed {
        logic            ready;
        tag_t            tag;    // producer when not ready
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        op_e            op;
        tag_t           dest;
        operand_t [1:0] src;
    } issue_t;

    typedef struct packed {
        logic            valid;
        tag_t            tag;
        logic [xlen-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic            valid;
        areg_t           rd;
        logic [xlen-1:0] value;
    } commit_t;

    // fill a waiting operand from whichever bus carries its tag
    function automatic operand_t snoop_operand(operand_t opnd, cdb_t bus_a, cdb_t bus_b);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus_a.valid && bus_a.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus_a.value;
        end else if (!opnd.ready && bus_b.valid && bus_b.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus_b.value;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alloc,
    input  areg_t          alloc_rd,
    input  tag_t [1:0]     lookup_tag,
    input  cdb_t           alu_cdb,
    input  cdb_t           mul_cdb,
    output logic           rob_full,
    output tag_t           rob_tail,
    output operand_t [1:0] lookup,
    output commit_t        commit,
    output tag_t           commit_tag
);

    areg_t           rd_q  [rob_depth];
    logic [xlen-1:0] val_q [rob_depth];
    logic [rob_depth-1:0] done_q;
    tag_t            head;
    tag_t            tail;
    rob_cnt_t        count;
    logic            retire;

    assign retire   = count != '0 && done_q[head];
    assign rob_full = count == rob_cnt_t'(rob_depth);
    assign rob_tail = tail;

    // done bits stay set after retire so a just-committed tag still reads
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup[i].ready = done_q[lookup_tag[i]];
            lookup[i].tag   = lookup_tag[i];
            lookup[i].value = val_q[lookup_tag[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done_q       <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (alloc) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (alu_cdb.valid) begin
                done_q[alu_cdb.tag] <= 1'b1;
            end
            if (mul_cdb.valid) begin
                done_q[mul_cdb.tag] <= 1'b1;
            end
            commit.valid <= retire;
            if (retire) begin
                commit.rd    <= rd_q[head];
                commit.value <= val_q[head];
                commit_tag   <= head;
                head         <= head + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail] <= alloc_rd;
        end
        if (alu_cdb.valid) begin
            val_q[alu_cdb.tag] <= alu_cdb.value;
        end
        if (mul_cdb.valid) begin
            val_q[mul_cdb.tag] <= mul_cdb.value;
        end
    end

endmodule

`default_nettype wire

/* dv/ooo_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_assert import ooo_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        inst_valid,
    input logic [31:0] inst,
    input logic        stall,
    input logic        alloc,
    input logic        rob_full,
    input logic        commit_valid,
    input cdb_t        alu_cdb,
    input cdb_t        mul_cdb
);

    int   fail_count = 0;
    logic r_ok;
    logic known_op;

    // rv32 subset of r-type alu and mul encodings plus addi
    assign r_ok = inst[6:0] == 7'b0110011 &&
                  ((inst[31:25] == 7'h00 && inst[14:12] inside {3'h0, 3'h2, 3'h4, 3'h6, 3'h7}) ||
                   ((inst[31:25] == 7'h20 || inst[31:25] == 7'h01) && inst[14:12] == 3'h0));
    assign known_op = r_ok || (inst[6:0] == 7'b0010011 && inst[14:12] == 3'h0);

    assert property (@(posedge clk) !rst_n |=> !commit_valid)
        else begin
            fail_count++;
            $error("commit valid after a reset cycle");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_cdb.valid && mul_cdb.valid && alu_cdb.tag == mul_cdb.tag))
        else begin
            fail_count++;
            $error("both result buses carry the same tag");
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(alloc && rob_full))
        else begin
            fail_count++;
            $error("rob allocated while full");
        end

    assert property (@(posedge clk) disable iff (!rst_n) (inst_valid && !known_op) |-> !stall)
        else begin
            fail_count++;
            $error("stall raised for an unsupported word");
        end

endmodule

bind ooo_core ooo_core_assert assert_i (
    .clk, .rst_n, .inst_valid, .inst, .stall, .alloc, .rob_full,
    .commit_valid (commit.valid),
    .alu_cdb, .mul_cdb
);

`default_nettype wire

/* dv/tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

    localparam int word_budget = 240;  // upper bound on words sent
    localparam int wd_cycles   = word_budget * (mul_steps + 4) + 100;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        stall;
    commit_t     commit;

    logic [xlen-1:0] model_regs [num_arch_regs];
    commit_t         exp_q [$];  // expected commits in program order
    int              checks;
    int              errors;
    int              tests;
    int              test_checks;
    int              test_errors;

    ooo_core dut_i (.clk, .rst_n, .inst_valid, .inst, .stall, .commit);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rtype_word(op_e op, logic [4:0] rd, logic [4:0] rs1,
                                               logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        case (op)
            op_and:  f3 = 3'h7;
            op_or:   f3 = 3'h6;
            op_xor:  f3 = 3'h4;
            op_slt:  f3 = 3'h2;
            default: f3 = 3'h0;
        endcase
        f7 = (op == op_sub) ? 7'h20 : (op == op_mul) ? 7'h01 : 7'h00;
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // low registers only so dependencies are frequent
    function automatic logic [31:0] random_word();
        logic [2:0] sel;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        sel = 3'($urandom_range(0, 7));
        rd  = 5'($urandom_range(0, 15));
        rs1 = 5'($urandom_range(0, 15));
        rs2 = 5'($urandom_range(0, 15));
        if (sel == 3'd7) begin
            return addi_word(rd, rs1, 12'($urandom));
        end
        return rtype_word(op_e'(sel), rd, rs1, rs2);
    endfunction

    // executes one accepted word in program order
    task automatic model_step(logic [31:0] w);
        logic [4:0]      rd;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        logic            ok;
        rd  = w[11:7];
        a   = model_regs[w[19:15]];
        b   = model_regs[w[24:20]];
        res = '0;
        ok  = 1'b1;
        if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            res = a + {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == 7'b0110011) begin
            case ({w[31:25], w[14:12]})
                {7'h00, 3'h0}: res = a + b;
                {7'h20, 3'h0}: res = a - b;
                {7'h00, 3'h7}: res = a & b;
                {7'h00, 3'h6}: res = a | b;
                {7'h00, 3'h4}: res = a ^ b;
                {7'h00, 3'h2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                {7'h01, 3'h0}: res = a * b;  // low word
                default:       ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        if (ok) begin
            exp_q.push_back('{valid: 1'b1, rd: rd, value: res});
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    // hold the word until an edge with stall low takes it
    task automatic send_word(logic [31:0] w);
        logic taken;
        inst       = w;
        inst_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stall;
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
        model_step(w);
    endtask

    task automatic finish_test(string name);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // room for stray commits
        #1;
        tests++;
        $display("%-12s done: %0d commits checked, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    always @(negedge clk) begin : check_commit
        commit_t head;
        if (rst_n && commit.valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("commit to x%0d arrived with no instruction pending", commit.rd);
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                checks++;
                assert (commit.rd == head.rd) else begin
                    errors++;
                    $display("CHECK FAILED commit.rd got %h expected %h", commit.rd, head.rd);
                end
                assert (commit.value == head.value) else begin
                    errors++;
                    $display("CHECK FAILED commit.value got %h expected %h",
                             commit.value, head.value);
                end
            end
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", wd_cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he20));
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        test_checks = 0;
        test_errors = 0;
        for (int i = 0; i < num_arch_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        inst       = addi_word(5'd1, 5'd0, 12'h001);  // offered only, no edge takes it
        inst_valid = 1'b1;
        #1;
        assert (!stall && !commit.valid) else begin
            errors++;
            $display("stall or commit valid is high right after reset");
        end

        send_word(addi_word(5'd1, 5'd0, 12'($urandom)));
        send_word(addi_word(5'd2, 5'd0, 12'($urandom)));
        send_word(rtype_word(op_add, 5'd3, 5'd1, 5'd2));
        send_word(rtype_word(op_sub, 5'd4, 5'd1, 5'd2));
        send_word(rtype_word(op_and, 5'd5, 5'd1, 5'd2));
        send_word(rtype_word(op_or, 5'd6, 5'd1, 5'd2));
        send_word(rtype_word(op_xor, 5'd7, 5'd1, 5'd2));
        send_word(rtype_word(op_slt, 5'd8, 5'd1, 5'd2));
        send_word(rtype_word(op_slt, 5'd9, 5'd2, 5'd1));
        finish_test("independent");

        send_word(addi_word(5'd10, 5'd0, 12'h7f3));
        send_word(rtype_word(op_add, 5'd11, 5'd10, 5'd10));
        send_word(rtype_word(op_sub, 5'd12, 5'd11, 5'd1));
        send_word(rtype_word(op_xor, 5'd13, 5'd12, 5'd11));
        send_word(rtype_word(op_and, 5'd14, 5'd13, 5'd12));
        send_word(rtype_word(op_or, 5'd15, 5'd14, 5'd13));
        send_word(rtype_word(op_slt, 5'd16, 5'd15, 5'd10));
        send_word(addi_word(5'd17, 5'd16, 12'h064));
        send_word(rtype_word(op_add, 5'd17, 5'd17, 5'd17));
        finish_test("chains");

        send_word(rtype_word(op_mul, 5'd18, 5'd11, 5'd12));
        send_word(rtype_word(op_add, 5'd19, 5'd3, 5'd4));
        send_word(rtype_word(op_xor, 5'd20, 5'd1, 5'd3));
        send_word(rtype_word(op_or, 5'd21, 5'd2, 5'd4));
        send_word(rtype_word(op_add, 5'd22, 5'd18, 5'd19));  // waits on the product
        send_word(rtype_word(op_mul, 5'd23, 5'd18, 5'd18));
        send_word(rtype_word(op_sub, 5'd24, 5'd23, 5'd22));
        finish_test("mul_order");

        for (int n = 0; n < 200; n++) begin
            send_word(random_word());
        end
        finish_test("random");

        send_word(addi_word(5'd0, 5'd0, 12'h037));
        send_word(rtype_word(op_add, 5'd0, 5'd1, 5'd2));
        send_word(rtype_word(op_add, 5'd25, 5'd0, 5'd1));
        send_word(32'h0000_2003);  // load is not supported
        send_word(32'h0000_006f);
        send_word(rtype_word(op_mul, 5'd26, 5'd0, 5'd1));
        send_word({7'h7f, 5'd2, 5'd1, 3'h0, 5'd27, 7'b0110011});
        send_word(addi_word(5'd28, 5'd0, 12'h001));
        send_word(rtype_word(op_sub, 5'd29, 5'd0, 5'd28));
        finish_test("x0_unsup");

        $display("summary: %0d tests, %0d commits checked, %0d errors, %0d assertion failures",
                 tests, checks, errors, dut_i.assert_i.fail_count);
        if (errors == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/ooo_pkg.sv
design/dispatch_control.sv
design/reorder_buffer.sv
design/arch_regfile.sv
design/alu_station.sv
design/mul_station.sv
design/ooo_core.sv
dv/ooo_core_assert.sv
dv/tb_ooo_core.sv
